/* hw/disp_config.svh */
// Sizing constants for the dispatch stage.
// Both packages and the testbench include this header. Every width in the
// stage derives from these values.

`ifndef DISP_CONFIG_SVH
`define DISP_CONFIG_SVH

// data path width
`define DISP_XLEN 32

// architectural register address width
`define DISP_REG_AW 5

// outstanding load entries, one per commit id
`define DISP_SB_DEPTH 4

// must cover DISP_SB_DEPTH entries
`define DISP_CID_W 2

`endif

/* hw/disp_isa_pkg.sv */
// Operation codes of the RV32 subset handled by dispatch.
// Also holds helpers that map an operation to its function unit.

`include "disp_config.svh"

package disp_isa_pkg;

    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_LUI, OP_AUIPC,
        OP_JAL, OP_JALR, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW
    } op_e;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_BJP,
        UNIT_MEM
    } unit_e;

    function automatic logic op_is_load(op_e op);
        return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    endfunction

    function automatic logic op_is_store(op_e op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

    function automatic unit_e op_unit(op_e op);
        if (op_is_load(op) || op_is_store(op)) begin
            return UNIT_MEM;
        end
        if (op inside {OP_JAL, OP_JALR, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU}) begin
            return UNIT_BJP;
        end
        return UNIT_ALU;
    endfunction

endpackage

/* hw/disp_pipe_pkg.sv */
// Data path types shared across the dispatch stage.
// Widths come from the config header.

`include "disp_config.svh"

package disp_pipe_pkg;

    // one data word
    typedef logic [`DISP_XLEN-1:0] xlen_t;

    // register file address
    typedef logic [`DISP_REG_AW-1:0] reg_addr_t;

    // scoreboard entry index, returned on commit
    typedef logic [`DISP_CID_W-1:0] cid_t;

    // one bit per byte lane of a data word
    typedef logic [`DISP_XLEN/8-1:0] byte_mask_t;

endpackage

/* hw/dispatch_req_if.sv */
// Per-unit request fields from the operand logic to the pipeline register.
// All fields are combinational from the current decode inputs.

`timescale 1ns/1ps

interface dispatch_req_if;
    import disp_pipe_pkg::*;

    // ALU
    logic       req_alu;
    xlen_t      alu_op1;
    xlen_t      alu_op2;

    // branch and jump
    logic       req_bjp;
    xlen_t      bjp_target;
    xlen_t      bjp_link_pc;
    logic       op1_eq_op2;
    logic       op1_ge_op2_signed;
    logic       op1_ge_op2_unsigned;

    // load and store
    logic       req_mem;
    logic       mem_load;
    xlen_t      mem_addr;
    byte_mask_t mem_wmask;
    xlen_t      mem_wdata;
    logic       misaligned_load;
    logic       misaligned_store;

    modport src (
        output req_alu, alu_op1, alu_op2,
        output req_bjp, bjp_target, bjp_link_pc,
        output op1_eq_op2, op1_ge_op2_signed, op1_ge_op2_unsigned,
        output req_mem, mem_load, mem_addr, mem_wmask, mem_wdata,
        output misaligned_load, misaligned_store
    );

    // mem_load goes to the hazard unit by a top-level wire instead
    modport dst (
        input req_alu, alu_op1, alu_op2,
        input req_bjp, bjp_target, bjp_link_pc,
        input op1_eq_op2, op1_ge_op2_signed, op1_ge_op2_unsigned,
        input req_mem, mem_addr, mem_wmask, mem_wdata,
        input misaligned_load, misaligned_store
    );

endinterface

/* hw/dispatch_hdu.sv */
// Hazard detection for the dispatch stage.
// Tracks outstanding loads in a small scoreboard indexed by commit id.
// Stalls readers or writers of a pending destination, and loads while full.

`timescale 1ns/1ps
`include "disp_config.svh"

module dispatch_hdu (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     inst_valid_i,
    input  logic                     stall_i,
    input  logic                     mem_load_i,
    input  disp_pipe_pkg::reg_addr_t rd_addr_i,
    input  disp_pipe_pkg::reg_addr_t rs1_addr_i,
    input  disp_pipe_pkg::reg_addr_t rs2_addr_i,
    input  logic                     rd_we_i,
    input  logic                     rs1_re_i,
    input  logic                     rs2_re_i,
    input  logic                     commit_valid_i,
    input  disp_pipe_pkg::cid_t      commit_id_i,
    output logic                     hazard_stall_o,
    output disp_pipe_pkg::cid_t      alloc_id_o
);
    import disp_pipe_pkg::*;

    localparam int DEPTH = `DISP_SB_DEPTH;

    logic [DEPTH-1:0] sb_valid;
    reg_addr_t        sb_rd [DEPTH];

    logic [DEPTH-1:0] rs1_hit;
    logic [DEPTH-1:0] rs2_hit;
    logic [DEPTH-1:0] rd_hit;
    logic             rs1_use;
    logic             rs2_use;
    logic             rd_use;
    logic             sb_full;
    cid_t             free_id;
    logic             alloc_en;

    // x0 never creates a dependency
    assign rs1_use = rs1_re_i && (rs1_addr_i != '0);
    assign rs2_use = rs2_re_i && (rs2_addr_i != '0);
    assign rd_use  = rd_we_i && (rd_addr_i != '0);

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            rs1_hit[i] = sb_valid[i] && (sb_rd[i] == rs1_addr_i);
            rs2_hit[i] = sb_valid[i] && (sb_rd[i] == rs2_addr_i);
            rd_hit[i]  = sb_valid[i] && (sb_rd[i] == rd_addr_i);
        end
    end

    // scan from the top so the lowest free entry wins
    always_comb begin
        free_id = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!sb_valid[i]) begin
                free_id = cid_t'(i);
            end
        end
    end

    assign sb_full = &sb_valid;

    assign hazard_stall_o = inst_valid_i && ((rs1_use && |rs1_hit) ||
                                             (rs2_use && |rs2_hit) ||
                                             (rd_use && |rd_hit) ||
                                             (mem_load_i && sb_full));

    assign alloc_en   = inst_valid_i && !stall_i && !hazard_stall_o && mem_load_i && rd_use;
    assign alloc_id_o = alloc_en ? free_id : '0;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sb_valid <= '0;
        end else begin
            // commit and allocation never hit the same entry
            if (commit_valid_i) begin
                sb_valid[commit_id_i] <= 1'b0;
            end
            if (alloc_en) begin
                sb_valid[free_id] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            sb_rd[free_id] <= rd_addr_i;
        end
    end

endmodule

/* hw/dispatch_logic.sv */
// Operand generation for the dispatch stage.
// Picks the function unit of the decoded operation and computes its
// operands: ALU inputs, branch target and flags, memory address and lanes.

`timescale 1ns/1ps

module dispatch_logic (
    input  disp_isa_pkg::op_e    dec_op_i,
    input  logic                 dec_use_imm_i,
    input  disp_pipe_pkg::xlen_t dec_imm_i,
    input  disp_pipe_pkg::xlen_t dec_pc_i,
    input  disp_pipe_pkg::xlen_t rs1_rdata_i,
    input  disp_pipe_pkg::xlen_t rs2_rdata_i,
    dispatch_req_if.src          req
);
    import disp_isa_pkg::*;
    import disp_pipe_pkg::*;

    unit_e unit;
    xlen_t jalr_sum;
    xlen_t mem_addr;
    logic  is_half;
    logic  is_word;
    logic  misaligned;

    assign unit        = op_unit(dec_op_i);
    assign req.req_alu = (unit == UNIT_ALU);
    assign req.req_bjp = (unit == UNIT_BJP);
    assign req.req_mem = (unit == UNIT_MEM);

    // ALU operand select
    always_comb begin
        case (dec_op_i)
            OP_LUI: begin
                req.alu_op1 = '0;
                req.alu_op2 = dec_imm_i;
            end
            OP_AUIPC: begin
                req.alu_op1 = dec_pc_i;
                req.alu_op2 = dec_imm_i;
            end
            default: begin
                req.alu_op1 = rs1_rdata_i;
                req.alu_op2 = dec_use_imm_i ? dec_imm_i : rs2_rdata_i;
            end
        endcase
    end

    // jalr target drops bit 0
    assign jalr_sum        = rs1_rdata_i + dec_imm_i;
    assign req.bjp_target  = (dec_op_i == OP_JALR) ? {jalr_sum[$bits(xlen_t)-1:1], 1'b0}
                                                   : dec_pc_i + dec_imm_i;
    assign req.bjp_link_pc = dec_pc_i + xlen_t'(4);

    assign req.op1_eq_op2          = (rs1_rdata_i == rs2_rdata_i);
    assign req.op1_ge_op2_signed   = ($signed(rs1_rdata_i) >= $signed(rs2_rdata_i));
    assign req.op1_ge_op2_unsigned = (rs1_rdata_i >= rs2_rdata_i);

    assign mem_addr     = rs1_rdata_i + dec_imm_i;
    assign req.mem_addr = mem_addr;
    assign req.mem_load = op_is_load(dec_op_i);

    // byte lanes and replicated store data
    always_comb begin
        req.mem_wmask = '0;
        req.mem_wdata = rs2_rdata_i;
        case (dec_op_i)
            OP_SB: begin
                req.mem_wmask = byte_mask_t'(1) << mem_addr[1:0];
                req.mem_wdata = {4{rs2_rdata_i[7:0]}};
            end
            OP_SH: begin
                req.mem_wmask = mem_addr[1] ? 4'b1100 : 4'b0011;
                req.mem_wdata = {2{rs2_rdata_i[15:0]}};
            end
            OP_SW: begin
                req.mem_wmask = '1;
            end
            default: begin
                req.mem_wmask = '0;
            end
        endcase
    end

    // access still goes out, the memory unit traps on the flag
    assign is_half    = dec_op_i inside {OP_LH, OP_LHU, OP_SH};
    assign is_word    = dec_op_i inside {OP_LW, OP_SW};
    assign misaligned = (is_half && mem_addr[0]) || (is_word && (mem_addr[1:0] != 2'b00));

    assign req.misaligned_load  = misaligned && op_is_load(dec_op_i);
    assign req.misaligned_store = misaligned && op_is_store(dec_op_i);

endmodule

/* hw/dispatch_pipe.sv */
// Issue register of the dispatch stage.
// Captures the request fields of an accepted instruction for one cycle of
// latency. Holds everything while stall_i is high, loads a bubble otherwise.

`timescale 1ns/1ps

module dispatch_pipe (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      stall_i,
    input  logic                      accept_i,
    input  disp_isa_pkg::op_e         dec_op_i,
    input  disp_pipe_pkg::reg_addr_t  rd_addr_i,
    input  logic                      rd_we_i,
    input  disp_pipe_pkg::cid_t       alloc_id_i,
    dispatch_req_if.dst               req,

    output logic                      issue_valid_o,
    output disp_pipe_pkg::cid_t       commit_id_o,
    output logic                      pipe_reg_we_o,
    output disp_pipe_pkg::reg_addr_t  pipe_reg_waddr_o,

    output logic                      req_alu_o,
    output disp_isa_pkg::op_e         alu_op_o,
    output disp_pipe_pkg::xlen_t      alu_op1_o,
    output disp_pipe_pkg::xlen_t      alu_op2_o,

    output logic                      req_bjp_o,
    output disp_isa_pkg::op_e         bjp_op_o,
    output disp_pipe_pkg::xlen_t      bjp_target_o,
    output disp_pipe_pkg::xlen_t      bjp_link_pc_o,
    output logic                      op1_eq_op2_o,
    output logic                      op1_ge_op2_signed_o,
    output logic                      op1_ge_op2_unsigned_o,

    output logic                      req_mem_o,
    output disp_isa_pkg::op_e         mem_op_o,
    output disp_pipe_pkg::xlen_t      mem_addr_o,
    output disp_pipe_pkg::xlen_t      mem_wdata_o,
    output disp_pipe_pkg::byte_mask_t mem_wmask_o,
    output logic                      misaligned_load_o,
    output logic                      misaligned_store_o
);
    import disp_isa_pkg::*;

    op_e op_q;

    // valid, request strobes and trap flags, cleared on a bubble
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            issue_valid_o      <= 1'b0;
            req_alu_o          <= 1'b0;
            req_bjp_o          <= 1'b0;
            req_mem_o          <= 1'b0;
            pipe_reg_we_o      <= 1'b0;
            misaligned_load_o  <= 1'b0;
            misaligned_store_o <= 1'b0;
            commit_id_o        <= '0;
        end else if (!stall_i) begin
            issue_valid_o      <= accept_i;
            req_alu_o          <= accept_i && req.req_alu;
            req_bjp_o          <= accept_i && req.req_bjp;
            req_mem_o          <= accept_i && req.req_mem;
            pipe_reg_we_o      <= accept_i && rd_we_i;
            misaligned_load_o  <= accept_i && req.misaligned_load;
            misaligned_store_o <= accept_i && req.misaligned_store;
            // zero unless this instruction took a scoreboard entry
            commit_id_o        <= alloc_id_i;
        end
    end

    // payload only means something under its request strobe
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            op_q                  <= dec_op_i;
            pipe_reg_waddr_o      <= rd_addr_i;
            alu_op1_o             <= req.alu_op1;
            alu_op2_o             <= req.alu_op2;
            bjp_target_o          <= req.bjp_target;
            bjp_link_pc_o         <= req.bjp_link_pc;
            op1_eq_op2_o          <= req.op1_eq_op2;
            op1_ge_op2_signed_o   <= req.op1_ge_op2_signed;
            op1_ge_op2_unsigned_o <= req.op1_ge_op2_unsigned;
            mem_addr_o            <= req.mem_addr;
            mem_wdata_o           <= req.mem_wdata;
            mem_wmask_o           <= req.mem_wmask;
        end
    end

    assign alu_op_o = op_q;
    assign bjp_op_o = op_q;
    assign mem_op_o = op_q;

endmodule

/* hw/dispatch.sv */
// Dispatch stage of the RV32 integer core.
// Takes one decoded instruction per cycle, checks it against outstanding
// loads and issues ALU, branch or memory operands one cycle after acceptance.

`timescale 1ns/1ps

module dispatch (
    input  logic                      clk,
    input  logic                      rst_n_i,

    // decode
    input  logic                      inst_valid_i,
    input  disp_isa_pkg::op_e         dec_op_i,
    input  logic                      dec_use_imm_i,
    input  disp_pipe_pkg::xlen_t      dec_imm_i,
    input  disp_pipe_pkg::xlen_t      dec_pc_i,
    input  disp_pipe_pkg::xlen_t      rs1_rdata_i,
    input  disp_pipe_pkg::xlen_t      rs2_rdata_i,
    input  disp_pipe_pkg::reg_addr_t  rd_addr_i,
    input  disp_pipe_pkg::reg_addr_t  rs1_addr_i,
    input  disp_pipe_pkg::reg_addr_t  rs2_addr_i,
    input  logic                      rd_we_i,
    input  logic                      rs1_re_i,
    input  logic                      rs2_re_i,

    // control
    input  logic                      stall_i,
    input  logic                      commit_valid_i,
    input  disp_pipe_pkg::cid_t       commit_id_i,
    output logic                      hazard_stall_o,
    output logic                      issue_valid_o,
    output disp_pipe_pkg::cid_t       commit_id_o,
    output logic                      pipe_reg_we_o,
    output disp_pipe_pkg::reg_addr_t  pipe_reg_waddr_o,

    // to ALU
    output logic                      req_alu_o,
    output disp_isa_pkg::op_e         alu_op_o,
    output disp_pipe_pkg::xlen_t      alu_op1_o,
    output disp_pipe_pkg::xlen_t      alu_op2_o,

    // to branch unit
    output logic                      req_bjp_o,
    output disp_isa_pkg::op_e         bjp_op_o,
    output disp_pipe_pkg::xlen_t      bjp_target_o,
    output disp_pipe_pkg::xlen_t      bjp_link_pc_o,
    output logic                      op1_eq_op2_o,
    output logic                      op1_ge_op2_signed_o,
    output logic                      op1_ge_op2_unsigned_o,

    // to memory unit
    output logic                      req_mem_o,
    output disp_isa_pkg::op_e         mem_op_o,
    output disp_pipe_pkg::xlen_t      mem_addr_o,
    output disp_pipe_pkg::xlen_t      mem_wdata_o,
    output disp_pipe_pkg::byte_mask_t mem_wmask_o,
    output logic                      misaligned_load_o,
    output logic                      misaligned_store_o
);
    import disp_pipe_pkg::*;

    logic mem_load;
    logic accept;
    cid_t alloc_id;

    dispatch_req_if req_if ();

    assign mem_load = req_if.mem_load;
    assign accept   = inst_valid_i && !hazard_stall_o && !stall_i;

    dispatch_hdu u_hdu (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .inst_valid_i   (inst_valid_i),
        .stall_i        (stall_i),
        .mem_load_i     (mem_load),
        .rd_addr_i      (rd_addr_i),
        .rs1_addr_i     (rs1_addr_i),
        .rs2_addr_i     (rs2_addr_i),
        .rd_we_i        (rd_we_i),
        .rs1_re_i       (rs1_re_i),
        .rs2_re_i       (rs2_re_i),
        .commit_valid_i (commit_valid_i),
        .commit_id_i    (commit_id_i),
        .hazard_stall_o (hazard_stall_o),
        .alloc_id_o     (alloc_id)
    );

    dispatch_logic u_logic (
        .dec_op_i      (dec_op_i),
        .dec_use_imm_i (dec_use_imm_i),
        .dec_imm_i     (dec_imm_i),
        .dec_pc_i      (dec_pc_i),
        .rs1_rdata_i   (rs1_rdata_i),
        .rs2_rdata_i   (rs2_rdata_i),
        .req           (req_if.src)
    );

    dispatch_pipe u_pipe (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .stall_i               (stall_i),
        .accept_i              (accept),
        .dec_op_i              (dec_op_i),
        .rd_addr_i             (rd_addr_i),
        .rd_we_i               (rd_we_i),
        .alloc_id_i            (alloc_id),
        .req                   (req_if.dst),
        .issue_valid_o         (issue_valid_o),
        .commit_id_o           (commit_id_o),
        .pipe_reg_we_o         (pipe_reg_we_o),
        .pipe_reg_waddr_o      (pipe_reg_waddr_o),
        .req_alu_o             (req_alu_o),
        .alu_op_o              (alu_op_o),
        .alu_op1_o             (alu_op1_o),
        .alu_op2_o             (alu_op2_o),
        .req_bjp_o             (req_bjp_o),
        .bjp_op_o              (bjp_op_o),
        .bjp_target_o          (bjp_target_o),
        .bjp_link_pc_o         (bjp_link_pc_o),
        .op1_eq_op2_o          (op1_eq_op2_o),
        .op1_ge_op2_signed_o   (op1_ge_op2_signed_o),
        .op1_ge_op2_unsigned_o (op1_ge_op2_unsigned_o),
        .req_mem_o             (req_mem_o),
        .mem_op_o              (mem_op_o),
        .mem_addr_o            (mem_addr_o),
        .mem_wdata_o           (mem_wdata_o),
        .mem_wmask_o           (mem_wmask_o),
        .misaligned_load_o     (misaligned_load_o),
        .misaligned_store_o    (misaligned_store_o)
    );

endmodule

/* testbench/dispatch_sva.sv */
// Protocol assertions for the dispatch stage.
// Bound into every instance of the top level.

`timescale 1ns/1ps

module dispatch_sva (
    input logic                 clk,
    input logic                 rst_n_i,
    input logic                 inst_valid_i,
    input logic                 stall_i,
    input logic                 hazard_stall_o,
    input logic                 issue_valid_o,
    input logic                 req_alu_o,
    input logic                 req_bjp_o,
    input logic                 req_mem_o,
    input disp_pipe_pkg::xlen_t alu_op1_o,
    input disp_pipe_pkg::xlen_t bjp_target_o,
    input disp_pipe_pkg::xlen_t mem_addr_o
);

    // one unit per issued instruction
    assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({req_alu_o, req_bjp_o, req_mem_o}))
        else $error("more than one unit request");

    assert property (@(posedge clk) disable iff (!rst_n_i)
        !issue_valid_o |-> !(req_alu_o || req_bjp_o || req_mem_o))
        else $error("unit request without issue");

    assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> $stable({issue_valid_o, req_alu_o, req_bjp_o, req_mem_o,
                             alu_op1_o, bjp_target_o, mem_addr_o}))
        else $error("issue outputs moved under stall");

    assert property (@(posedge clk) disable iff (!rst_n_i)
        !inst_valid_i |-> !hazard_stall_o)
        else $error("hazard stall without instruction");

endmodule

bind dispatch dispatch_sva u_sva (.*);

/* testbench/tb_dispatch.sv */
// Testbench for the dispatch stage.
// Drives ALU, branch and memory instructions, models the load scoreboard
// and checks every issued instruction against a reference function.

`timescale 1ns/1ps
`include "disp_config.svh"

module tb_dispatch;
    import disp_isa_pkg::*;
    import disp_pipe_pkg::*;

    typedef struct packed {
        logic       req_alu;
        logic       req_bjp;
        logic       req_mem;
        xlen_t      alu_op1;
        xlen_t      alu_op2;
        xlen_t      target;
        xlen_t      link;
        logic       eq;
        logic       ges;
        logic       geu;
        xlen_t      addr;
        xlen_t      wdata;
        byte_mask_t wmask;
        logic       mis_ld;
        logic       mis_st;
    } exp_t;

    logic clk, rst_n_i, inst_valid_i, dec_use_imm_i, rd_we_i, rs1_re_i, rs2_re_i;
    logic stall_i, commit_valid_i;
    op_e dec_op_i;
    xlen_t dec_imm_i, dec_pc_i, rs1_rdata_i, rs2_rdata_i;
    reg_addr_t rd_addr_i, rs1_addr_i, rs2_addr_i;
    cid_t commit_id_i;
    logic hazard_stall_o, issue_valid_o, pipe_reg_we_o;
    cid_t commit_id_o;
    reg_addr_t pipe_reg_waddr_o;
    logic req_alu_o, req_bjp_o, req_mem_o;
    op_e alu_op_o, bjp_op_o, mem_op_o;
    xlen_t alu_op1_o, alu_op2_o, bjp_target_o, bjp_link_pc_o, mem_addr_o, mem_wdata_o;
    logic op1_eq_op2_o, op1_ge_op2_signed_o, op1_ge_op2_unsigned_o;
    byte_mask_t mem_wmask_o;
    logic misaligned_load_o, misaligned_store_o;

    integer seed = 32'he11f_dbe2;

    // scoreboard model and expected issue
    logic [`DISP_SB_DEPTH-1:0] sb_v;
    reg_addr_t sb_rd [`DISP_SB_DEPTH];
    exp_t exp_q;
    logic exp_valid, exp_we;
    op_e exp_op;
    reg_addr_t exp_rd;
    cid_t exp_cid;

    dispatch dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function int rnd();
        rnd = $random(seed);
    endfunction

    function automatic exp_t ref_dispatch(op_e op, logic use_imm, xlen_t imm, xlen_t pc,
                                          xlen_t a, xlen_t b);
        exp_t e;
        logic half, word, mis;
        e = '0;
        e.req_mem = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};
        e.req_bjp = op inside {OP_JAL, OP_JALR, OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
                               OP_BLTU, OP_BGEU};
        e.req_alu = !e.req_mem && !e.req_bjp;
        e.alu_op1 = (op == OP_LUI) ? 32'd0 : (op == OP_AUIPC) ? pc : a;
        e.alu_op2 = (op == OP_LUI || op == OP_AUIPC || use_imm) ? imm : b;
        e.target  = (op == OP_JALR) ? ((a + imm) & 32'hffff_fffe) : pc + imm;
        e.link    = pc + 32'd4;
        e.eq      = (a == b);
        e.ges     = ($signed(a) >= $signed(b));
        e.geu     = (a >= b);
        e.addr    = a + imm;
        e.wdata   = b;
        if (op == OP_SB) begin
            e.wmask = 4'b0001 << e.addr[1:0];
            e.wdata = {b[7:0], b[7:0], b[7:0], b[7:0]};
        end else if (op == OP_SH) begin
            e.wmask = e.addr[1] ? 4'b1100 : 4'b0011;
            e.wdata = {b[15:0], b[15:0]};
        end else if (op == OP_SW) begin
            e.wmask = 4'b1111;
        end
        half     = op inside {OP_LH, OP_LHU, OP_SH};
        word     = op inside {OP_LW, OP_SW};
        mis      = (half && e.addr[0]) || (word && |e.addr[1:0]);
        e.mis_ld = mis && (op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU});
        e.mis_st = mis && (op inside {OP_SB, OP_SH, OP_SW});
        return e;
    endfunction

    task automatic check(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // compare outputs and step the scoreboard model at every edge
    always @(posedge clk) begin
        logic pred;
        cid_t free;
        if (!rst_n_i) begin
            sb_v      = '0;
            exp_valid = 1'b0;
        end else begin
            check("issue_valid_o", issue_valid_o, exp_valid);
            check("req_alu_o", req_alu_o, exp_valid && exp_q.req_alu);
            check("req_bjp_o", req_bjp_o, exp_valid && exp_q.req_bjp);
            check("req_mem_o", req_mem_o, exp_valid && exp_q.req_mem);
            if (exp_valid) begin
                check("commit_id_o", commit_id_o, exp_cid);
                check("pipe_reg_we_o", pipe_reg_we_o, exp_we);
                check("pipe_reg_waddr_o", pipe_reg_waddr_o, exp_rd);
                check("misaligned_load_o", misaligned_load_o, exp_q.mis_ld);
                check("misaligned_store_o", misaligned_store_o, exp_q.mis_st);
                if (exp_q.req_alu) begin
                    check("alu_op_o", alu_op_o, exp_op);
                    check("alu_op1_o", alu_op1_o, exp_q.alu_op1);
                    check("alu_op2_o", alu_op2_o, exp_q.alu_op2);
                end
                if (exp_q.req_bjp) begin
                    check("bjp_op_o", bjp_op_o, exp_op);
                    check("bjp_target_o", bjp_target_o, exp_q.target);
                    check("bjp_link_pc_o", bjp_link_pc_o, exp_q.link);
                    check("op1_eq_op2_o", op1_eq_op2_o, exp_q.eq);
                    check("op1_ge_op2_signed_o", op1_ge_op2_signed_o, exp_q.ges);
                    check("op1_ge_op2_unsigned_o", op1_ge_op2_unsigned_o, exp_q.geu);
                end
                if (exp_q.req_mem) begin
                    check("mem_op_o", mem_op_o, exp_op);
                    check("mem_addr_o", mem_addr_o, exp_q.addr);
                    check("mem_wmask_o", mem_wmask_o, exp_q.wmask);
                    if (exp_q.wmask != 0) begin
                        check("mem_wdata_o", mem_wdata_o, exp_q.wdata);
                    end
                end
            end
            // hazard prediction from the model state before this edge
            pred = 1'b0;
            free = '0;
            for (int i = `DISP_SB_DEPTH - 1; i >= 0; i--) begin
                if (sb_v[i] && ((rs1_re_i && rs1_addr_i != 0 && sb_rd[i] == rs1_addr_i) ||
                                (rs2_re_i && rs2_addr_i != 0 && sb_rd[i] == rs2_addr_i) ||
                                (rd_we_i && rd_addr_i != 0 && sb_rd[i] == rd_addr_i))) begin
                    pred = 1'b1;
                end
                if (!sb_v[i]) begin
                    free = cid_t'(i);
                end
            end
            if (dec_op_i inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU} && &sb_v) begin
                pred = 1'b1;
            end
            pred = pred && inst_valid_i;
            check("hazard_stall_o", hazard_stall_o, pred);
            if (commit_valid_i) begin
                sb_v[commit_id_i] = 1'b0;
            end
            if (!stall_i) begin
                exp_valid = inst_valid_i && !pred;
                exp_q     = ref_dispatch(dec_op_i, dec_use_imm_i, dec_imm_i, dec_pc_i,
                                         rs1_rdata_i, rs2_rdata_i);
                exp_op    = dec_op_i;
                exp_rd    = rd_addr_i;
                exp_we    = rd_we_i;
                exp_cid   = '0;
                if (exp_valid && rd_we_i && rd_addr_i != 0 &&
                    dec_op_i inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU}) begin
                    exp_cid     = free;
                    sb_v[free]  = 1'b1;
                    sb_rd[free] = rd_addr_i;
                end
            end
        end
    end

    // present one instruction and hold it until the edge that accepts it
    task automatic issue(op_e op, logic use_imm, xlen_t imm, xlen_t a, xlen_t b,
                         reg_addr_t rd, reg_addr_t rs1, logic we, logic re1);
        int cnt;
        @(posedge clk);
        inst_valid_i  <= 1'b1;
        dec_op_i      <= op;
        dec_use_imm_i <= use_imm;
        dec_imm_i     <= imm;
        dec_pc_i      <= xlen_t'(rnd());
        rs1_rdata_i   <= a;
        rs2_rdata_i   <= b;
        rd_addr_i     <= rd;
        rs1_addr_i    <= rs1;
        rs2_addr_i    <= '0;
        rd_we_i       <= we;
        rs1_re_i      <= re1;
        rs2_re_i      <= 1'b0;
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
            if (cnt > 50) begin
                $display("Simulation failed");
                $fatal(1, "instruction was never accepted");
            end
        end while (hazard_stall_o || stall_i);
        inst_valid_i <= 1'b0;
    endtask

    task automatic commit(cid_t id);
        @(posedge clk);
        commit_valid_i <= 1'b1;
        commit_id_i    <= id;
        @(posedge clk);
        commit_valid_i <= 1'b0;
    endtask

    initial begin
        cid_t id;
        xlen_t snap;
        xlen_t op_a;
        reg_addr_t rd;
        {inst_valid_i, dec_use_imm_i, rd_we_i, rs1_re_i, rs2_re_i} = '0;
        {stall_i, commit_valid_i, commit_id_i} = '0;
        {dec_imm_i, dec_pc_i, rs1_rdata_i, rs2_rdata_i} = '0;
        {rd_addr_i, rs1_addr_i, rs2_addr_i} = '0;
        dec_op_i = OP_ADD;
        rst_n_i  = 1'b0;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        @(posedge clk);
        check("reset issue_valid_o", issue_valid_o, 0);
        check("reset req", {req_alu_o, req_bjp_o, req_mem_o}, 0);
        check("reset hazard_stall_o", hazard_stall_o, 0);
        // ALU operand select
        for (int i = 0; i < 40; i++) begin
            issue(op_e'(5'(rnd() & 7)), rnd() & 1, rnd(), rnd(), rnd(), 5'(rnd()), 0, 1, 0);
        end
        // branch and jump, every fourth with equal operands
        for (int i = 0; i < 40; i++) begin
            op_a = rnd();
            issue(op_e'(5'(8 + (rnd() & 7))), 0, rnd(), op_a, (i % 4 == 0) ? op_a : rnd(),
                  5'(rnd()), 0, 1, 0);
        end
        // loads and stores at every offset, rd x0 so nothing is allocated
        for (int op = 16; op < 24; op++) begin
            for (int off = 0; off < 4; off++) begin
                issue(op_e'(5'(op)), 1, (rnd() & ~32'h3) | off, rnd() & ~32'h3, rnd(), 0, 0,
                      1, 0);
            end
        end
        // load followed by a reader of its destination
        issue(OP_LW, 1, 32'h10, 32'h1000, 0, 5'd5, 0, 1, 0);
        @(posedge clk);
        id = commit_id_o;
        fork
            issue(OP_ADD, 0, 0, rnd(), rnd(), 5'd6, 5'd5, 1, 1);
            begin
                repeat (3) @(posedge clk);
                check("hazard_stall_o on reader", hazard_stall_o, 1);
                commit(id);
            end
        join
        // downstream back-pressure holds the issue register
        issue(OP_XOR, 0, 0, rnd(), rnd(), 5'd7, 0, 1, 0);
        stall_i <= 1'b1;
        @(posedge clk);
        snap = alu_op1_o;
        // a new instruction waits on the inputs while the stall lasts
        fork
            issue(OP_OR, 0, 0, rnd(), rnd(), 5'd8, 0, 1, 0);
            begin
                repeat (5) begin
                    @(posedge clk);
                    check("alu_op1_o under stall", alu_op1_o, snap);
                    check("issue_valid_o under stall", issue_valid_o, 1);
                end
                stall_i <= 1'b0;
            end
        join
        // fill the scoreboard
        for (int i = 0; i < 4; i++) begin
            issue(OP_LW, 1, 0, rnd() & ~32'h3, 0, 5'(i + 1), 0, 1, 0);
            @(posedge clk);
            check("commit_id_o while filling", commit_id_o, i);
        end
        fork
            issue(OP_LH, 1, 0, 32'h200, 0, 5'd9, 0, 1, 0);
            begin
                repeat (3) @(posedge clk);
                check("hazard_stall_o when full", hazard_stall_o, 1);
                commit(2);
            end
        join
        @(posedge clk);
        check("commit_id_o after free", commit_id_o, 2);
        // random commits interleaved with loads the model says can go
        for (int i = 0; i < 30; i++) begin
            commit(cid_t'(rnd()));
            @(negedge clk);
            rd = 5'(1 + ($unsigned(rnd()) % 31));
            if (!(&sb_v) && !(sb_v[0] && sb_rd[0] == rd) && !(sb_v[1] && sb_rd[1] == rd) &&
                !(sb_v[2] && sb_rd[2] == rd) && !(sb_v[3] && sb_rd[3] == rd)) begin
                issue(OP_LBU, 1, rnd(), rnd(), 0, rd, 0, 1, 0);
            end
        end
        for (int i = 0; i < 4; i++) begin
            commit(cid_t'(i));
        end
        repeat (3) @(posedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* sources.f */
+incdir+hw
hw/disp_isa_pkg.sv
hw/disp_pipe_pkg.sv
hw/dispatch_req_if.sv
hw/dispatch_hdu.sv
hw/dispatch_logic.sv
hw/dispatch_pipe.sv
hw/dispatch.sv
testbench/dispatch_sva.sv
testbench/tb_dispatch.sv

/* run.sh */
#!/bin/sh
# Build and run the dispatch testbench with Verilator.
# The exit status is that of the simulation.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_dispatch -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/Vtb_dispatch
status=$?
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit $status
fi

exit 0
